// File: logic/cmp_settings.svh
`ifndef CMP_SETTINGS_SVH
`define CMP_SETTINGS_SVH

// reservation station entries in the compare unit
`define NUM_CMP_RS 3

// ROB tags, tag 0 stands for no dependency so only 1..7 are handed out
`define ROB_DEPTH 8

`define TAG_W 3

`endif

// File: logic/cmp_pkg.sv
`default_nettype none

`include "cmp_settings.svh"

package cmp_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [`TAG_W-1:0] tag_t;

    // encodings are the funct3 field of the RV32I branch instructions
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef struct packed {
        logic           is_br;    // 0 for the slt/sltu style compares
        branch_funct3_t cmp_op;
        rv32i_word      Vj;
        rv32i_word      Vk;
        tag_t           Qj;       // zero once Vj holds the operand
        tag_t           Qk;
        tag_t           dest;
        logic           br_pred;  // predicted taken
        rv32i_word      pc;
        rv32i_word      b_imm;
    } cmp_dispatch_t;

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        rv32i_word val;
    } cdb_write_t;

    // the ROB view that the station watches for wakeup
    typedef struct packed {
        logic [`ROB_DEPTH-1:0]      ready;
        rv32i_word [`ROB_DEPTH-1:0] vals;
    } rob_out_t;

    typedef struct packed {
        logic      valid;
        rv32i_word val;
        tag_t      tag;
        logic      br_pred_res;  // 1 when the prediction matched the outcome
        rv32i_word pc_next;
    } cmp_lane_t;

    typedef cmp_lane_t [`NUM_CMP_RS-1:0] cmp_cdb_t;

endpackage

`default_nettype wire

// File: logic/branch_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
    input  cmp_pkg::rv32i_word      a,
    input  cmp_pkg::rv32i_word      b,
    input  cmp_pkg::branch_funct3_t cmp_op,
    output logic                    taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    // slt and sltu reuse the blt and bltu codes
    always_comb begin
        case (cmp_op)
            cmp_pkg::beq:  taken = eq;
            cmp_pkg::bne:  taken = !eq;
            cmp_pkg::blt:  taken = lt_s;
            cmp_pkg::bge:  taken = !lt_s;
            cmp_pkg::bltu: taken = lt_u;
            cmp_pkg::bgeu: taken = !lt_u;
            default:       taken = 1'b0;  // funct3 010 and 011 never reach the unit
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cmp_rs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmp_settings.svh"

module cmp_rs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  cmp_pkg::cmp_dispatch_t disp,
    input  cmp_pkg::rob_out_t      rob_data,
    output cmp_pkg::cmp_cdb_t      cmp_res
);

    localparam int IDX_W = $clog2(`NUM_CMP_RS);

    logic [`NUM_CMP_RS-1:0]  busy;
    cmp_pkg::cmp_dispatch_t  ent [`NUM_CMP_RS];

    logic [IDX_W-1:0]        free_idx;
    logic                    free_found;
    logic                    disp_fire;
    logic [`NUM_CMP_RS-1:0]  load;      // entry written by this dispatch
    logic [`NUM_CMP_RS-1:0]  issue;     // busy with both operands present
    logic [`NUM_CMP_RS-1:0]  taken;

    for (genvar i = 0; i < `NUM_CMP_RS; i++) begin : g_cmp
        branch_cmp i_branch_cmp (
            .a      (ent[i].Vj),
            .b      (ent[i].Vk),
            .cmp_op (ent[i].cmp_op),
            .taken  (taken[i])
        );
    end

    // walk down from the top so the lowest free entry wins
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = `NUM_CMP_RS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx   = IDX_W'(i);
                free_found = 1'b1;
            end
        end
    end

    assign disp_ready = free_found;
    assign disp_fire  = disp_valid && disp_ready;

    always_comb begin
        for (int i = 0; i < `NUM_CMP_RS; i++) begin
            load[i]  = disp_fire && (free_idx == IDX_W'(i));
            issue[i] = busy[i] && (ent[i].Qj == '0) && (ent[i].Qk == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < `NUM_CMP_RS; i++) begin
                if (issue[i]) begin
                    busy[i] <= 1'b0;
                end else if (load[i]) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    // a loaded entry waits one edge before it can capture from the table
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_CMP_RS; i++) begin
            if (load[i]) begin
                ent[i] <= disp;
            end else if (busy[i]) begin
                if (ent[i].Qj != '0 && rob_data.ready[ent[i].Qj]) begin
                    ent[i].Vj <= rob_data.vals[ent[i].Qj];
                    ent[i].Qj <= '0;
                end
                if (ent[i].Qk != '0 && rob_data.ready[ent[i].Qk]) begin
                    ent[i].Vk <= rob_data.vals[ent[i].Qk];
                    ent[i].Qk <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `NUM_CMP_RS; i++) begin
                cmp_res[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `NUM_CMP_RS; i++) begin
                cmp_res[i].valid <= issue[i];
                if (issue[i]) begin
                    cmp_res[i].tag         <= ent[i].dest;
                    cmp_res[i].br_pred_res <= (ent[i].br_pred == taken[i]);
                    // a branch reports its own pc, a compare reports a full-width flag
                    if (ent[i].is_br) begin
                        cmp_res[i].val <= ent[i].pc;
                    end else begin
                        cmp_res[i].val <= {32{taken[i]}};
                    end
                    if (taken[i]) begin
                        cmp_res[i].pc_next <= ent[i].pc + ent[i].b_imm;
                    end else begin
                        cmp_res[i].pc_next <= ent[i].pc + 32'd4;
                    end
                end
            end
        end
    end

    // dispatch may stall only while every entry holds an instruction
    a_stall_only_full: assert property (
        @(posedge clk) disable iff (rst)
        !disp_ready |-> &busy
    ) else $error("disp_ready low while an entry is free");

    for (genvar i = 0; i < `NUM_CMP_RS; i++) begin : g_lane_chk
        a_tag_nonzero: assert property (
            @(posedge clk) disable iff (rst)
            cmp_res[i].valid |-> (cmp_res[i].tag != '0)
        ) else $error("lane %0d reports tag 0", i);

        for (genvar j = i + 1; j < `NUM_CMP_RS; j++) begin : g_pair
            a_tag_unique: assert property (
                @(posedge clk) disable iff (rst)
                (cmp_res[i].valid && cmp_res[j].valid) |-> (cmp_res[i].tag != cmp_res[j].tag)
            ) else $error("lanes %0d and %0d carry the same tag", i, j);
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_value_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmp_settings.svh"

module rob_value_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                alloc_valid,
    input  cmp_pkg::tag_t       alloc_tag,
    input  cmp_pkg::cdb_write_t ext_cdb,
    input  cmp_pkg::cmp_cdb_t   cmp_res,
    output cmp_pkg::rob_out_t   rob_data
);

    logic [`ROB_DEPTH-1:0]               ready_q;
    cmp_pkg::rv32i_word [`ROB_DEPTH-1:0] vals_q;

    logic [`ROB_DEPTH-1:0]               wr_en;
    cmp_pkg::rv32i_word [`ROB_DEPTH-1:0] wr_val;
    logic [`ROB_DEPTH-1:0]               alloc_mask;
    logic                                alloc_clash;

    // merge the external bus and every compare lane into one write mask
    always_comb begin
        wr_en  = '0;
        wr_val = vals_q;
        if (ext_cdb.valid && ext_cdb.tag != '0) begin
            wr_en[ext_cdb.tag]  = 1'b1;
            wr_val[ext_cdb.tag] = ext_cdb.val;
        end
        for (int i = 0; i < `NUM_CMP_RS; i++) begin
            if (cmp_res[i].valid && cmp_res[i].tag != '0) begin
                wr_en[cmp_res[i].tag]  = 1'b1;
                wr_val[cmp_res[i].tag] = cmp_res[i].val;
            end
        end
    end

    always_comb begin
        alloc_mask = '0;
        if (alloc_valid) begin
            alloc_mask[alloc_tag] = 1'b1;  // the tag is reissued and its old value is stale
        end
    end

    assign alloc_clash = alloc_valid && wr_en[alloc_tag];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ready_q <= '0;
        end else begin
            ready_q <= (ready_q & ~alloc_mask) | wr_en;
        end
    end

    always_ff @(posedge clk) begin
        vals_q <= wr_val;
    end

    assign rob_data.ready = ready_q;
    assign rob_data.vals  = vals_q;

    // renaming must not hand out a tag whose result is landing in the same cycle
    a_alloc_vs_write: assert property (
        @(posedge clk) disable iff (rst || flush)
        !alloc_clash
    ) else $error("allocation of tag %0d collides with a write", alloc_tag);

endmodule

`default_nettype wire

// File: logic/cmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cmp_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  cmp_pkg::cmp_dispatch_t disp,
    input  cmp_pkg::cdb_write_t    ext_cdb,
    input  logic                   alloc_valid,
    input  cmp_pkg::tag_t          alloc_tag,
    output cmp_pkg::cmp_cdb_t      cmp_res
);

    cmp_pkg::rob_out_t rob_data;  // ready bits and values per tag

    cmp_rs i_cmp_rs (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp       (disp),
        .rob_data   (rob_data),
        .cmp_res    (cmp_res)
    );

    // compare results loop back here so dependent entries can wake up
    rob_value_table i_rob_value_table (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .ext_cdb     (ext_cdb),
        .cmp_res     (cmp_res),
        .rob_data    (rob_data)
    );

endmodule

`default_nettype wire

// File: dv/cmp_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cmp_settings.svh"

module cmp_unit_tb;

    localparam int NUM_DISP   = 74;  // dispatches made by the sequence below
    localparam int MAX_CYCLES = 40 * NUM_DISP + 200;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   disp_valid;
    logic                   disp_ready;
    cmp_pkg::cmp_dispatch_t disp;
    cmp_pkg::cdb_write_t    ext_cdb;
    logic                   alloc_valid;
    cmp_pkg::tag_t          alloc_tag;
    cmp_pkg::cmp_cdb_t      cmp_res;

    cmp_pkg::cmp_lane_t exp_lane [`ROB_DEPTH];  // expected lane per tag
    logic               exp_live [`ROB_DEPTH];  // a result for this tag may appear now
    int                 err_cnt = 0;
    int                 res_cnt = 0;
    int                 exp_cnt = 0;
    int                 cycle_cnt = 0;
    int                 tag_rr = 0;
    logic [31:0]        rng_state = 32'h2f142e71;

    cmp_unit i_cmp_unit (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp        (disp),
        .ext_cdb     (ext_cdb),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .cmp_res     (cmp_res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic cmp_pkg::branch_funct3_t op_of(input int k);
        case (k % 6)
            0:       return cmp_pkg::beq;
            1:       return cmp_pkg::bne;
            2:       return cmp_pkg::blt;
            3:       return cmp_pkg::bge;
            4:       return cmp_pkg::bltu;
            default: return cmp_pkg::bgeu;
        endcase
    endfunction

    function automatic logic ref_taken(input cmp_pkg::branch_funct3_t op,
                                       input logic [31:0] a, input logic [31:0] b);
        case (op)
            cmp_pkg::beq:  return a == b;
            cmp_pkg::bne:  return a != b;
            cmp_pkg::blt:  return $signed(a) < $signed(b);
            cmp_pkg::bge:  return !($signed(a) < $signed(b));
            cmp_pkg::bltu: return a < b;
            default:       return !(a < b);
        endcase
    endfunction

    // a and b are the operand values the entry will finally compare
    function automatic cmp_pkg::cmp_lane_t ref_lane(input cmp_pkg::cmp_dispatch_t d,
                                                    input logic [31:0] a, input logic [31:0] b);
        cmp_pkg::cmp_lane_t l;
        logic t;
        t             = ref_taken(d.cmp_op, a, b);
        l.valid       = 1'b1;
        l.tag         = d.dest;
        l.br_pred_res = (d.br_pred == t);
        l.val         = d.is_br ? d.pc : {32{t}};
        l.pc_next     = t ? d.pc + d.b_imm : d.pc + 32'd4;
        return l;
    endfunction

    // dest cycles through tags 1..4 so 5..7 stay free for waits
    function automatic cmp_pkg::cmp_dispatch_t make_disp(input logic is_br, input int op,
                                                         input logic [31:0] a,
                                                         input logic [31:0] b);
        cmp_pkg::cmp_dispatch_t d;
        logic [31:0] r;
        r         = xorshift();
        d.is_br   = is_br;
        d.cmp_op  = op_of(op);
        d.Vj      = a;
        d.Vk      = b;
        d.Qj      = '0;
        d.Qk      = '0;
        d.dest    = cmp_pkg::tag_t'(tag_rr % 4 + 1);
        d.br_pred = r[0];
        d.pc      = xorshift() & 32'hffff_fffc;
        d.b_imm   = {{19{r[12]}}, r[12:1], 1'b0};
        tag_rr++;
        return d;
    endfunction

    task automatic send(input cmp_pkg::cmp_dispatch_t d);
        @(negedge clk);
        disp        = d;
        disp_valid  = 1'b1;
        alloc_valid = 1'b1;
        alloc_tag   = d.dest;
        while (!disp_ready) @(negedge clk);
        @(negedge clk);
        disp_valid  = 1'b0;
        alloc_valid = 1'b0;
    endtask

    task automatic expect_res(input cmp_pkg::cmp_dispatch_t d, input logic [31:0] a,
                              input logic [31:0] b, input logic live);
        exp_lane[d.dest] = ref_lane(d, a, b);
        exp_live[d.dest] = live;
        exp_cnt++;
    endtask

    task automatic alloc_only(input int tag);
        @(negedge clk);
        alloc_valid = 1'b1;
        alloc_tag   = cmp_pkg::tag_t'(tag);
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    task automatic ext_write(input int tag, input logic [31:0] val);
        @(negedge clk);
        ext_cdb = '{valid: 1'b1, tag: cmp_pkg::tag_t'(tag), val: val};
        @(negedge clk);
        ext_cdb.valid = 1'b0;
    endtask

    task automatic wait_results(input int limit);
        int n = 0;
        while (res_cnt < exp_cnt && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (res_cnt < exp_cnt) begin
            err_cnt++;
            $display("at %0t only %0d of %0d results arrived in time", $time, res_cnt, exp_cnt);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (!rst) begin
            for (int i = 0; i < `NUM_CMP_RS; i++) begin
                if (cmp_res[i].valid) begin
                    res_cnt++;
                    exp_live[cmp_res[i].tag] = 1'b0;
                end
            end
        end
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    for (genvar i = 0; i < `NUM_CMP_RS; i++) begin : g_lane_chk
        a_lane_expected: assert property (
            @(posedge clk) disable iff (rst)
            cmp_res[i].valid |-> exp_live[cmp_res[i].tag]
        ) else begin
            err_cnt++;
            $display("at %0t lane %0d produced tag %0d that was not due", $time, i,
                     $sampled(cmp_res[i].tag));
        end

        a_lane_value: assert property (
            @(posedge clk) disable iff (rst)
            cmp_res[i].valid |-> (cmp_res[i] == exp_lane[cmp_res[i].tag])
        ) else begin
            err_cnt++;
            $display("[FAIL] %0t cmp_res[%0d] got %h exp %h", $time, i,
                     $sampled(cmp_res[i]), exp_lane[$sampled(cmp_res[i].tag)]);
        end
    end

    initial begin
        cmp_pkg::cmp_dispatch_t d;
        cmp_pkg::cmp_dispatch_t w [3];
        logic [31:0] edge_a [6];
        logic [31:0] edge_b [6];
        logic [31:0] a;
        logic [31:0] b;
        int n;
        edge_a = '{32'h0, 32'h80000000, 32'h0, 32'hffffffff, 32'h0, 32'h80000000};
        edge_b = '{32'h0, 32'h0, 32'h80000000, 32'h0, 32'hffffffff, 32'hffffffff};
        rst         = 1'b1;
        flush       = 1'b0;
        disp_valid  = 1'b0;
        disp        = '0;
        ext_cdb     = '0;
        alloc_valid = 1'b0;
        alloc_tag   = '0;
        for (int t = 0; t < `ROB_DEPTH; t++) begin
            exp_live[t] = 1'b0;
            exp_lane[t] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // set compares on edge and random operand pairs for every op
        for (int op = 0; op < 6; op++) begin
            for (int p = 0; p < 8; p++) begin
                a = (p < 6) ? edge_a[p] : xorshift();
                b = (p < 6) ? edge_b[p] : xorshift();
                d = make_disp(1'b0, op, a, b);
                expect_res(d, a, b, 1'b1);
                send(d);
            end
            wait_results(20);
        end

        // branches draw operands from a small range so equality shows up
        for (int k = 0; k < 12; k++) begin
            a = xorshift() & 32'h3;
            b = xorshift() & 32'h3;
            d = make_disp(1'b1, k, a, b);
            expect_res(d, a, b, 1'b1);
            send(d);
        end
        wait_results(20);

        // operands come from the external bus for Qj only, Qk only and then both
        for (int k = 0; k < 3; k++) begin
            alloc_only(5);
            alloc_only(6);
            a = xorshift();
            b = xorshift();
            d = make_disp(k == 2, k + 2, 32'hdeadbeef, 32'hdeadbeef);
            d.Qj = (k != 1) ? 3'd5 : 3'd0;
            d.Qk = (k != 0) ? 3'd6 : 3'd0;
            expect_res(d, (k != 1) ? a : 32'hdeadbeef, (k != 0) ? b : 32'hdeadbeef, 1'b0);
            send(d);
            repeat (4) @(negedge clk);
            if (k != 1) ext_write(5, a);
            if (k != 0) ext_write(6, b);
            // the lane is due only in the cycle after the second edge past the last write
            repeat (2) @(negedge clk);
            exp_live[d.dest] = 1'b1;
            wait_results(1);
        end

        // chains on the tag of an earlier compare result
        for (int k = 0; k < 2; k++) begin
            d = make_disp(1'b1, k, 32'h5, 32'h5);
            expect_res(d, 32'h5, 32'h5, 1'b1);
            send(d);
            w[0] = make_disp(1'b0, 4, 32'h0, 32'h7fffffff);
            w[0].Qj = d.dest;
            expect_res(w[0], exp_lane[d.dest].val, 32'h7fffffff, 1'b1);
            send(w[0]);
            wait_results(10);
        end

        // fill the station with entries waiting on tags 5..7 and hold one more
        alloc_only(5);
        alloc_only(6);
        alloc_only(7);
        for (int k = 0; k < 3; k++) begin
            w[k] = make_disp(1'b0, k, 32'h0, 32'h1);
            w[k].Qj = cmp_pkg::tag_t'(k + 5);
            expect_res(w[k], 32'h1, 32'h1, 1'b0);
            send(w[k]);
        end
        d = make_disp(1'b0, 5, 32'h3, 32'h9);
        expect_res(d, 32'h3, 32'h9, 1'b1);
        @(negedge clk);
        disp        = d;
        disp_valid  = 1'b1;
        alloc_valid = 1'b1;
        alloc_tag   = d.dest;
        repeat (5) begin
            a_full_stall: assert (!disp_ready) else begin
                err_cnt++;
                $display("[FAIL] %0t disp_ready got %b exp 0", $time, disp_ready);
            end
            @(negedge clk);
        end
        ext_cdb = '{valid: 1'b1, tag: 3'd5, val: 32'h1};
        @(negedge clk);
        ext_cdb.valid      = 1'b0;
        exp_live[w[0].dest] = 1'b1;
        n = 0;
        while (!disp_ready && n < 10) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        disp_valid  = 1'b0;
        alloc_valid = 1'b0;
        ext_write(6, 32'h1);
        exp_live[w[1].dest] = 1'b1;
        ext_write(7, 32'h1);
        exp_live[w[2].dest] = 1'b1;
        wait_results(10);

        // busy entries are flushed and their tags must never show up on a lane
        alloc_only(5);
        alloc_only(6);
        alloc_only(7);
        for (int k = 0; k < 3; k++) begin
            w[k] = make_disp(1'b0, k, 32'h0, 32'h0);
            w[k].Qk = cmp_pkg::tag_t'(k + 5);
            send(w[k]);
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        a_flush_ready: assert (disp_ready) else begin
            err_cnt++;
            $display("[FAIL] %0t disp_ready got %b exp 1", $time, disp_ready);
        end
        ext_write(5, 32'h0);
        ext_write(6, 32'h0);
        ext_write(7, 32'h0);
        repeat (8) @(negedge clk);
        if (res_cnt != exp_cnt) begin
            err_cnt++;
            $display("saw %0d results but %0d were expected", res_cnt, exp_cnt);
        end

        $display("errors %0d, results %0d of %0d", err_cnt, res_cnt, exp_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/cmp_pkg.sv
logic/branch_cmp.sv
logic/cmp_rs.sv
logic/rob_value_table.sv
logic/cmp_unit.sv
dv/cmp_unit_tb.sv

// File: Bender.yml
package:
  name: cmp_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/cmp_pkg.sv
      - logic/branch_cmp.sv
      - logic/cmp_rs.sv
      - logic/rob_value_table.sv
      - logic/cmp_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/cmp_unit_tb.sv
